/* icache_pkg.sv */
package icache_pkg;

    // ==========================================================================
    // fetch address and block geometry
    // ==========================================================================

    // byte address seen by the fetch unit
    parameter int ADDR_W = 32;

    // one instruction word
    parameter int INST_W = 32;

    // 8-byte block, bit 2 picks the word
    parameter int OFFSET_BITS = 3;

    // ==========================================================================
    // miss controller states
    // ==========================================================================

    typedef enum logic [1:0] {
        idle      = 2'd0,
        lookup    = 2'd1,
        request   = 2'd2,
        wait_data = 2'd3
    } fetch_state_t;

endpackage

/* axi_pkg.sv */
package axi_pkg;

    // ==========================================================================
    // AXI read channel
    // ==========================================================================

    // single beat carries one whole block
    parameter int BEAT_W = 64;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

/* tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
    parameter int SET_BITS = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                          fill,
    output logic                          hit,
    output logic                          hit_way,
    output logic                          fill_way
);

    localparam int TAG_W = icache_pkg::ADDR_W - SET_BITS - icache_pkg::OFFSET_BITS;
    localparam int SETS  = 1 << SET_BITS;

    // one tag per way per set
    logic [TAG_W-1:0] tags [2][SETS];
    logic [SETS-1:0]  valid [2];
    // next way to replace once both are valid
    logic [SETS-1:0]  victim;

    logic [SET_BITS-1:0] index;
    logic [TAG_W-1:0]    tag;
    logic                hit0;
    logic                hit1;

    assign index = fetch_addr[icache_pkg::OFFSET_BITS +: SET_BITS];
    assign tag   = fetch_addr[icache_pkg::ADDR_W-1 -: TAG_W];

    // ==========================================================================
    // lookup
    // ==========================================================================

    assign hit0    = valid[0][index] && (tags[0][index] == tag);
    assign hit1    = valid[1][index] && (tags[1][index] == tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    // invalid way first, else the per-set victim
    always_comb begin
        if (!valid[0][index]) begin
            fill_way = 1'b0;
        end else if (!valid[1][index]) begin
            fill_way = 1'b1;
        end else begin
            fill_way = victim[index];
        end
    end

    // ==========================================================================
    // fill
    // ==========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            valid[0] <= '0;
            valid[1] <= '0;
            victim   <= '0;
        end else if (fill) begin
            valid[fill_way][index] <= 1'b1;
            // point at the other way for next time
            victim[index] <= ~fill_way;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][index] <= tag;
        end
    end

    // a block is only ever filled on a miss, so it lives in one way at most
    one_way_hit: assert property (
        @(posedge clk) disable iff (rst)
        !(hit0 && hit1)
    );

endmodule

/* data_store.sv */
`timescale 1ns/1ps

module data_store #(
    parameter int SET_BITS = 8
) (
    input  logic                          clk,
    input  logic                          lookup_start,
    input  logic [icache_pkg::ADDR_W-1:0] pc,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                          fill,
    input  logic                          fill_way,
    input  logic [axi_pkg::BEAT_W-1:0]    fill_data,
    input  logic                          hit_way,
    output logic [icache_pkg::INST_W-1:0] word
);

    localparam int SETS = 1 << SET_BITS;
    localparam int LO   = icache_pkg::OFFSET_BITS;

    logic [axi_pkg::BEAT_W-1:0] blocks [2][SETS];
    logic [axi_pkg::BEAT_W-1:0] rd_block [2];
    logic [axi_pkg::BEAT_W-1:0] sel_block;

    logic [SET_BITS-1:0] rd_index;
    logic [SET_BITS-1:0] wr_index;

    // read uses pc directly, the latched address is not there yet
    assign rd_index = pc[LO +: SET_BITS];
    assign wr_index = fetch_addr[LO +: SET_BITS];

    // both ways read out, tag_store picks one a cycle later
    always_ff @(posedge clk) begin
        if (lookup_start) begin
            rd_block[0] <= blocks[0][rd_index];
            rd_block[1] <= blocks[1][rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            blocks[fill_way][wr_index] <= fill_data;
        end
    end

    // word select, bit 2 chooses the upper half
    assign sel_block = hit_way ? rd_block[1] : rd_block[0];
    assign word      = fetch_addr[LO-1] ? sel_block[axi_pkg::BEAT_W-1 -: icache_pkg::INST_W]
                                        : sel_block[icache_pkg::INST_W-1:0];

endmodule

/* fetch_fsm.sv */
`timescale 1ns/1ps

module fetch_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [icache_pkg::ADDR_W-1:0] pc,
    input  logic                          req,
    input  logic                          flush,
    input  logic                          hit,
    input  logic [icache_pkg::INST_W-1:0] word,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [axi_pkg::BEAT_W-1:0]    rdata,
    input  axi_pkg::axi_resp_t            rresp,
    output logic                          lookup_start,
    output logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    output logic                          fill,
    output logic [axi_pkg::BEAT_W-1:0]    fill_data,
    output logic                          ready,
    output logic                          inst_valid,
    output logic                          error,
    output logic [icache_pkg::INST_W-1:0] inst,
    output logic                          arvalid,
    output logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic                          rready
);

    localparam int LO = icache_pkg::OFFSET_BITS;

    icache_pkg::fetch_state_t state;
    icache_pkg::fetch_state_t state_next;

    // set by a flush while the bus is busy
    logic killed;
    logic in_lookup;
    logic lookup_hit;
    logic lookup_miss;
    logic ar_done;
    logic beat_done;
    logic deliver;
    logic resp_ok;

    assign in_lookup    = (state == icache_pkg::lookup);
    assign lookup_hit   = in_lookup && hit && !flush;
    assign lookup_miss  = in_lookup && !hit && !flush;
    assign ar_done      = arvalid && arready;
    assign beat_done    = rvalid && rready;
    assign resp_ok      = (rresp == axi_pkg::OKAY);
    // a flush in the beat cycle kills it as well
    assign deliver      = beat_done && !killed && !flush;

    assign ready        = (state == icache_pkg::idle);
    assign lookup_start = req && ready;
    assign rready       = (state == icache_pkg::wait_data);
    assign araddr       = {fetch_addr[icache_pkg::ADDR_W-1:LO], {LO{1'b0}}};
    assign fill         = deliver && resp_ok;
    assign fill_data    = rdata;

    // ==========================================================================
    // state machine
    // ==========================================================================

    always_comb begin
        state_next = state;
        unique case (state)
            icache_pkg::idle: begin
                if (req) begin
                    state_next = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                if (flush || hit) begin
                    state_next = icache_pkg::idle;
                end else begin
                    state_next = icache_pkg::request;
                end
            end
            icache_pkg::request: begin
                if (ar_done) begin
                    state_next = icache_pkg::wait_data;
                end
            end
            icache_pkg::wait_data: begin
                if (beat_done) begin
                    state_next = icache_pkg::idle;
                end
            end
            default: state_next = icache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_start) begin
            fetch_addr <= pc;
        end
    end

    // bus transfer still completes after a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            killed <= 1'b0;
        end else if (lookup_start) begin
            killed <= 1'b0;
        end else if (flush && (state == icache_pkg::request || rready)) begin
            killed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (lookup_miss) begin
            arvalid <= 1'b1;
        end else if (ar_done) begin
            arvalid <= 1'b0;
        end
    end

    // ==========================================================================
    // instruction output
    // ==========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
            error      <= 1'b0;
        end else begin
            inst_valid <= lookup_hit || deliver;
            if (lookup_hit) begin
                error <= 1'b0;
            end else if (beat_done) begin
                error <= !resp_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            inst <= word;
        end else if (beat_done) begin
            inst <= fetch_addr[LO-1] ? rdata[axi_pkg::BEAT_W-1 -: icache_pkg::INST_W]
                                     : rdata[icache_pkg::INST_W-1:0];
        end
    end

    ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    inst_valid_pulse: assert property (
        @(posedge clk) disable iff (rst)
        inst_valid |=> !inst_valid
    );

    // fetch requests only arrive while idle
    req_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        req |-> ready
    );

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int SET_BITS = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [icache_pkg::ADDR_W-1:0] pc,
    input  logic                          req,
    input  logic                          flush,
    output logic                          ready,
    output logic                          inst_valid,
    output logic                          error,
    output logic [icache_pkg::INST_W-1:0] inst,
    output logic                          arvalid,
    output logic [icache_pkg::ADDR_W-1:0] araddr,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [axi_pkg::BEAT_W-1:0]    rdata,
    input  axi_pkg::axi_resp_t            rresp,
    output logic                          rready
);

    logic                          lookup_start;
    logic [icache_pkg::ADDR_W-1:0] fetch_addr;
    logic                          fill;
    logic [axi_pkg::BEAT_W-1:0]    fill_data;
    logic                          hit;
    logic                          hit_way;
    logic                          fill_way;
    logic [icache_pkg::INST_W-1:0] word;

    fetch_fsm u_fetch_fsm (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .req          (req),
        .flush        (flush),
        .hit          (hit),
        .word         (word),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .lookup_start (lookup_start),
        .fetch_addr   (fetch_addr),
        .fill         (fill),
        .fill_data    (fill_data),
        .ready        (ready),
        .inst_valid   (inst_valid),
        .error        (error),
        .inst         (inst),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .rready       (rready)
    );

    tag_store #(
        .SET_BITS (SET_BITS)
    ) u_tag_store (
        .clk        (clk),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .fill       (fill),
        .hit        (hit),
        .hit_way    (hit_way),
        .fill_way   (fill_way)
    );

    data_store #(
        .SET_BITS (SET_BITS)
    ) u_data_store (
        .clk          (clk),
        .lookup_start (lookup_start),
        .pc           (pc),
        .fetch_addr   (fetch_addr),
        .fill         (fill),
        .fill_way     (fill_way),
        .fill_data    (fill_data),
        .hit_way      (hit_way),
        .word         (word)
    );

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem #(
    parameter int SEED = 32'h72a6_962c
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          arvalid,
    input  logic [icache_pkg::ADDR_W-1:0] araddr,
    output logic                          arready,
    output logic                          rvalid,
    output logic [axi_pkg::BEAT_W-1:0]    rdata,
    output axi_pkg::axi_resp_t            rresp,
    input  logic                          rready
);

    integer seed;
    int     delay;
    logic [icache_pkg::ADDR_W-1:0] addr;

    // ========================================================================
    // memory image
    // ========================================================================

    // every block is a hash of its whole block address
    function automatic logic [63:0] block_data(input logic [31:0] a);
        logic [31:0] b;
        b = {3'b000, a[31:3]};
        return {(b * 32'h9e37_79b1) ^ 32'h5a5a_1234, (~b * 32'h85eb_ca6b) ^ b};
    endfunction

    // top nibble F answers with a slave error
    function automatic logic err_block(input logic [31:0] a);
        return a[31:28] == 4'hf;
    endfunction

    initial begin
        seed    = SEED;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = axi_pkg::OKAY;
        addr    = '0;
    end

    // ========================================================================
    // one address, one beat
    // ========================================================================

    always begin
        @(negedge clk);
        if (!rst && arvalid) begin
            delay = int'($unsigned($random(seed)) % 4);
            repeat (delay) @(negedge clk);
            arready = 1'b1;
            addr    = araddr;
            @(negedge clk);
            arready = 1'b0;
            delay = int'($unsigned($random(seed)) % 5);
            repeat (delay) @(negedge clk);
            rvalid = 1'b1;
            rdata  = block_data(addr);
            rresp  = err_block(addr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
            // beat goes at the first edge that sees rready
            while (!rready) @(negedge clk);
            @(negedge clk);
            rvalid = 1'b0;
            rdata  = '0;
            rresp  = axi_pkg::OKAY;
        end
    end

endmodule

/* tb_icache_top.sv */
`timescale 1ns/1ps

module tb_icache_top;

    localparam int SET_BITS  = 8;
    localparam int SETS      = 1 << SET_BITS;
    localparam int OFF       = icache_pkg::OFFSET_BITS;
    localparam int TAG_W     = icache_pkg::ADDR_W - SET_BITS - OFF;
    localparam int RST_CYC   = 16;
    localparam int N_RANDOM  = 400;
    localparam int LIMIT     = (N_RANDOM + 40) * 40 + RST_CYC;

    logic clk, rst, req, flush, ready, inst_valid, error, arvalid, arready, rvalid, rready;
    logic [31:0] pc, inst, araddr;
    logic [63:0] rdata;
    axi_pkg::axi_resp_t rresp;

    integer seed;
    int     errors, checks, fetches, cycles;

    // reference model of the tag side
    logic [TAG_W-1:0] m_tag [2][SETS];
    logic [SETS-1:0]  m_valid [2];
    logic [SETS-1:0]  m_victim;

    icache_top #(.SET_BITS(SET_BITS)) UUT (
        .clk(clk), .rst(rst), .pc(pc), .req(req), .flush(flush),
        .ready(ready), .inst_valid(inst_valid), .error(error), .inst(inst),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

    tb_axi_mem #(.SEED(32'h72a6_962c)) mem (
        .clk(clk), .rst(rst), .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: run went past %0d cycles", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // ========================================================================
    // expected values
    // ========================================================================

    function automatic logic [31:0] expect_word(input logic [31:0] a);
        logic [31:0] b;
        logic [63:0] blk;
        b   = {3'b000, a[31:3]};
        blk = {(b * 32'h9e37_79b1) ^ 32'h5a5a_1234, (~b * 32'h85eb_ca6b) ^ b};
        return a[2] ? blk[63:32] : blk[31:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // fmode 0 plain, 1 flush in lookup, 2 flush once arvalid shows
    task automatic run_fetch(input logic [31:0] addr, input int fmode);
        logic [SET_BITS-1:0] idx;
        logic [TAG_W-1:0]    tg;
        logic exp_hit, exp_err, exp_valid, exp_ar, way;
        logic saw_ar, got_valid, got_err, done;
        logic [31:0] got_inst;
        int edges, lat;
        idx = addr[OFF +: SET_BITS];
        tg  = addr[31 -: TAG_W];
        exp_hit = (m_valid[0][idx] && m_tag[0][idx] == tg)
               || (m_valid[1][idx] && m_tag[1][idx] == tg);
        exp_err   = !exp_hit && addr[31:28] == 4'hf;
        exp_ar    = fmode != 1 && !exp_hit;
        exp_valid = fmode != 1 && !(fmode == 2 && !exp_hit);
        saw_ar = 1'b0;
        got_valid = 1'b0;
        got_err = 1'b0;
        got_inst = '0;
        lat = 0;
        edges = 0;
        done = 1'b0;
        fetches++;
        @(negedge clk);
        pc  = addr;
        req = 1'b1;
        @(negedge clk);
        // the edge that took req is the first one
        edges++;
        req = 1'b0;
        if (fmode == 1) flush = 1'b1;
        while (!done) begin
            @(negedge clk);
            flush = 1'b0;
            edges++;
            if (arvalid && !saw_ar) begin
                saw_ar = 1'b1;
                check_value("araddr", 64'(araddr), 64'(addr & ~32'h7));
                if (fmode == 2) flush = 1'b1;
            end
            // beat is awaited only between the address transfer and the return to idle
            check_value("rready", 64'(rready), 64'(saw_ar && !arvalid && !ready));
            if (inst_valid) begin
                got_valid = 1'b1;
                got_inst  = inst;
                got_err   = error;
                lat       = edges;
            end
            if (ready) done = 1'b1;
        end
        check_value("arvalid", 64'(saw_ar), 64'(exp_ar));
        check_value("inst_valid", 64'(got_valid), 64'(exp_valid));
        if (got_valid && exp_valid) begin
            check_value("error", 64'(got_err), 64'(exp_err));
            if (!exp_err) check_value("inst", 64'(got_inst), 64'(expect_word(addr)));
            if (exp_hit) check_value("hit latency", 64'(lat), 64'd2);
        end
        // fill only on a clean, unflushed miss
        if (!exp_hit && fmode == 0 && !exp_err) begin
            if (!m_valid[0][idx]) way = 1'b0;
            else if (!m_valid[1][idx]) way = 1'b1;
            else way = m_victim[idx];
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
            m_victim[idx]     = ~way;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s done, %0d fetches so far, %0d errors so far", name, fetches, errors);
    endtask

    // ========================================================================
    // tests
    // ========================================================================

    initial begin : main
        logic [31:0] a;
        int r;
        seed = 32'h72a6_962c;
        errors = 0;
        checks = 0;
        fetches = 0;
        rst = 1'b1;
        req = 1'b0;
        flush = 1'b0;
        pc = '0;
        m_valid[0] = '0;
        m_valid[1] = '0;
        m_victim = '0;
        repeat (RST_CYC) @(negedge clk);
        rst = 1'b0;
        check_value("ready", 64'(ready), 64'd1);
        check_value("arvalid", 64'(arvalid), 64'd0);
        check_value("rready", 64'(rready), 64'd0);
        check_value("inst_valid", 64'(inst_valid), 64'd0);
        check_value("error", 64'(error), 64'd0);

        run_fetch(32'h0000_0100, 0);
        run_fetch(32'h0000_020c, 0);
        run_fetch(32'h0000_0318, 0);
        report_test("cold_miss");

        run_fetch(32'h0000_0104, 0);
        run_fetch(32'h0000_0208, 0);
        run_fetch(32'h0000_031c, 0);
        report_test("hit");

        // three tags in set 5
        run_fetch(32'h0000_0028, 0);
        run_fetch(32'h0000_0828, 0);
        run_fetch(32'h0000_102c, 0);
        run_fetch(32'h0000_082c, 0);
        run_fetch(32'h0000_0028, 0);
        run_fetch(32'h0000_1028, 0);
        run_fetch(32'h0000_0828, 0);
        report_test("replace");

        run_fetch(32'hf000_0040, 0);
        run_fetch(32'hf000_0044, 0);
        run_fetch(32'h0000_0040, 0);
        report_test("slverr");

        run_fetch(32'h0000_0060, 1);
        run_fetch(32'h0000_0068, 2);
        run_fetch(32'h0000_0100, 1);
        run_fetch(32'h0000_0064, 0);
        run_fetch(32'h0000_006c, 0);
        report_test("flush");

        // 4 tags over 4 sets, one tag in the error region
        repeat (N_RANDOM) begin
            r = int'($unsigned($random(seed)) % 4);
            a = (r == 3) ? 32'hf000_0000 : 32'(r) << 11;
            a = a | (32'($unsigned($random(seed)) % 4) << 3);
            a = a | (32'($unsigned($random(seed)) % 2) << 2);
            r = int'($unsigned($random(seed)) % 10);
            run_fetch(a, (r < 2) ? r + 1 : 0);
        end
        report_test("random");

        $display("fetches %0d, checks %0d, errors %0d", fetches, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* icache_top.f */
icache_pkg.sv
axi_pkg.sv
tag_store.sv
data_store.sv
fetch_fsm.sv
icache_top.sv
tb_axi_mem.sv
tb_icache_top.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_icache_top \
    -f icache_top.f \
    -o sim_icache &&
./obj_dir/sim_icache | tee /dev/stderr | grep -q '^\*\* PASS \*\*$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
